//--- Bender.yml
package:
  name: gt_bringup

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/gt_pkg.sv
      - rtl/cdr_lock_filter.sv
      - rtl/phalign_done_qual.sv
      - rtl/gt_reset_fsm.sv
      - rtl/link_word_codec.sv
      - rtl/gt_bringup_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/gt_bringup_checker.sv
      - tb/gt_bringup_asserts.sv
      - tb/gt_bringup_tb.sv

//--- all.f
+incdir+rtl
rtl/gt_pkg.sv
rtl/cdr_lock_filter.sv
rtl/phalign_done_qual.sv
rtl/gt_reset_fsm.sv
rtl/link_word_codec.sv
rtl/gt_bringup_top.sv
tb/gt_bringup_checker.sv
tb/gt_bringup_asserts.sv
tb/gt_bringup_tb.sv

//--- rtl/cdr_lock_filter.sv
`timescale 1ns/100ps
`default_nettype none

`include "gt_consts.svh"

module cdr_lock_filter (
	input wire logic CPLLLOCKDETCLK,
	input wire logic reset,
	input wire logic cdrlock_i,
	output logic cdr_locked_o
);

	logic [$clog2(`GT_LOCK_MAX+1)-1:0] unlock_cnt;

	always_ff @(posedge CPLLLOCKDETCLK or posedge reset) begin
		if (reset) begin
			unlock_cnt <= '0;
			cdr_locked_o <= 1'b0;
		end else if (!cdrlock_i) begin
			// ride through short drops, give up once the count is full
			if (unlock_cnt != `GT_LOCK_MAX) begin
				unlock_cnt <= unlock_cnt + 1'b1;
			end else begin
				cdr_locked_o <= 1'b0;
			end
		end else begin
			unlock_cnt <= '0;
			cdr_locked_o <= 1'b1; // relock is taken at once
		end
	end

endmodule

`default_nettype wire

//--- rtl/gt_bringup_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "gt_consts.svh"

module gt_bringup_top #(
	parameter logic [31:0] tmo_short = `GT_TMO_SHORT_DEF,
	parameter logic [31:0] tmo_long = `GT_TMO_LONG_DEF,
	parameter logic [31:0] cdr_stable = `GT_CDR_STABLE_DEF
) (
	input wire logic CPLLLOCKDETCLK,
	input wire logic reset,
	input wire gt_pkg::gt_status_t status_i,
	input wire gt_pkg::link_word_t rx_word_i,
	input wire logic [`GT_DBYTE-1:0] rx_err_i,
	input wire gt_pkg::link_word_t tx_user_word_i,
	input wire logic stb_txphase_i,
	input wire logic bypass_txphcheck_i,
	input wire logic [15:0] txphase_i,
	input wire logic [4:0] txphtarget_i,
	output wire gt_pkg::gt_ctrl_t ctrl_o,
	output wire gt_pkg::link_word_t tx_word_o,
	output wire logic done_o,
	output wire logic [15:0] attempts_o
);

	wire logic cdrlock_sync;
	wire logic txph_sync;
	wire logic rxph_sync;
	wire logic cdr_locked;
	wire logic tx_phdone;
	wire logic rx_phdone;
	wire logic align1_seen;
	wire logic align2_seen;
	wire logic rx_err;
	wire gt_pkg::link_req_t req;

	gt_reset_fsm #(
		.tmo_short(tmo_short),
		.tmo_long(tmo_long),
		.cdr_stable(cdr_stable)
	) u_fsm (
		.CPLLLOCKDETCLK(CPLLLOCKDETCLK),
		.reset(reset),
		.status_i(status_i),
		.cdr_locked_i(cdr_locked),
		.tx_phdone_i(tx_phdone),
		.rx_phdone_i(rx_phdone),
		.align1_seen_i(align1_seen),
		.align2_seen_i(align2_seen),
		.rx_err_i(rx_err),
		.stb_txphase_i(stb_txphase_i),
		.txphase_i(txphase_i),
		.txphtarget_i(txphtarget_i),
		.bypass_txphcheck_i(bypass_txphcheck_i),
		.cdrlock_sync_o(cdrlock_sync),
		.txph_sync_o(txph_sync),
		.rxph_sync_o(rxph_sync),
		.ctrl_o(ctrl_o),
		.req_o(req),
		.done_o(done_o),
		.attempts_o(attempts_o)
	);

	cdr_lock_filter u_cdr_filter (
		.CPLLLOCKDETCLK(CPLLLOCKDETCLK),
		.reset(reset),
		.cdrlock_i(cdrlock_sync),
		.cdr_locked_o(cdr_locked)
	);

	// each aligner is qualified against its own delay reset
	phalign_done_qual u_tx_qual (
		.CPLLLOCKDETCLK(CPLLLOCKDETCLK),
		.reset(reset),
		.dly_sreset_i(ctrl_o.txdly_sreset),
		.phaligndone_i(txph_sync),
		.qualified_o(tx_phdone)
	);

	phalign_done_qual u_rx_qual (
		.CPLLLOCKDETCLK(CPLLLOCKDETCLK),
		.reset(reset),
		.dly_sreset_i(ctrl_o.rxdly_sreset),
		.phaligndone_i(rxph_sync),
		.qualified_o(rx_phdone)
	);

	link_word_codec u_codec (
		.CPLLLOCKDETCLK(CPLLLOCKDETCLK),
		.reset(reset),
		.req_i(req),
		.tx_user_word_i(tx_user_word_i),
		.rx_word_i(rx_word_i),
		.rx_err_i(rx_err_i),
		.tx_word_o(tx_word_o),
		.align1_seen_o(align1_seen),
		.align2_seen_o(align2_seen),
		.rx_err_o(rx_err)
	);

endmodule

`default_nettype wire

//--- rtl/gt_consts.svh
`ifndef GT_CONSTS_SVH
`define GT_CONSTS_SVH

// link word geometry
`define GT_DWIDTH 16
`define GT_DBYTE 2

// 8b/10b marker bytes
`define GT_COMMA_K 8'hBC // K28.5
`define GT_SEQ_ALIGN1 8'h01
`define GT_SEQ_ALIGN2 8'h02
`define GT_SEQ_ALIGN3 8'h03

// step lengths in CPLLLOCKDETCLK cycles
`define GT_WAIT_500NS 200
`define GT_CPLL_PULSE 2
`define GT_PMA_PULSE 100
`define GT_DLY_PULSE 5
`define GT_ALIGN_HOLD 100 // marker hold during handshake
`define GT_LOCK_MAX 3 // tolerated cdr unlock cycles

`define GT_TMO_SHORT_DEF 32'h40000000
`define GT_TMO_LONG_DEF 32'hC0000000 // pma reset-done can be slow
`define GT_CDR_STABLE_DEF 32'h01000000

`endif

//--- rtl/gt_pkg.sv
`default_nettype none

`include "gt_consts.svh"

package gt_pkg;

	// bring-up sequencer states
	typedef enum logic [4:0] {
		IDLE, TX_WAIT, CPLL_RESET, CPLL_WAIT, MMCM_WAIT,
		PMA_TX_RESET, PMA_TX_WAIT, PMA_RX_RESET, PMA_RX_WAIT,
		TXDLY_RESET, TXDLY_WAIT, PH_STB1, PH_STB2, PH_CHECK,
		RX_WAIT, CDR_WAIT, CDR_STABLE, RXDLY_RESET, RXDLY_WAIT,
		ALIGN1, ALIGN2, ALIGN2_CHK, ALIGN3, DATA,
		RX_ERR, TX_TMO, RX_TMO
	} fsm_state_t;

	// raw transceiver status, asynchronous to the sequencer
	typedef struct packed {
		logic cpll_lock;
		logic cpll_fbclk_lost;
		logic cpll_refclk_lost;
		logic mmcm_lock;
		logic tx_resetdone;
		logic rx_resetdone;
		logic tx_phaligndone;
		logic rx_phaligndone;
		logic rx_cdrlock;
		logic rx_byteisaligned;
	} gt_status_t;

	typedef struct packed {
		logic cpll_reset;
		logic mmcm_reset;
		logic gttx_reset;
		logic gtrx_reset;
		logic txdly_sreset;
		logic rxdly_sreset;
	} gt_ctrl_t;

	// code value doubles as the marker sequence number
	typedef enum logic [1:0] {
		REQ_COMMA, REQ_ALIGN1, REQ_ALIGN2, REQ_ALIGN3
	} req_code_t;

	typedef struct packed {
		req_code_t req;
		logic seldata; // overrides req with user data
	} link_req_t;

	typedef struct packed {
		logic [7:0] seq; // high byte carries the sequence number
		logic [7:0] k28;
		logic [`GT_DBYTE-1:0] k;
	} marker_view_t;

	typedef struct packed {
		logic [`GT_DWIDTH-1:0] data;
		logic [`GT_DBYTE-1:0] k;
	} raw_view_t;

	typedef union packed {
		marker_view_t marker;
		raw_view_t raw;
	} link_word_t;

endpackage

`default_nettype wire

//--- rtl/gt_reset_fsm.sv
`timescale 1ns/100ps
`default_nettype none

`include "gt_consts.svh"

module gt_reset_fsm #(
	parameter logic [31:0] tmo_short = `GT_TMO_SHORT_DEF,
	parameter logic [31:0] tmo_long = `GT_TMO_LONG_DEF,
	parameter logic [31:0] cdr_stable = `GT_CDR_STABLE_DEF
) (
	input wire logic CPLLLOCKDETCLK,
	input wire logic reset,
	input wire gt_pkg::gt_status_t status_i,
	input wire logic cdr_locked_i,
	input wire logic tx_phdone_i,
	input wire logic rx_phdone_i,
	input wire logic align1_seen_i,
	input wire logic align2_seen_i,
	input wire logic rx_err_i,
	input wire logic stb_txphase_i,
	input wire logic [15:0] txphase_i,
	input wire logic [4:0] txphtarget_i,
	input wire logic bypass_txphcheck_i,
	output logic cdrlock_sync_o,
	output logic txph_sync_o,
	output logic rxph_sync_o,
	output gt_pkg::gt_ctrl_t ctrl_o,
	output gt_pkg::link_req_t req_o,
	output logic done_o,
	output logic [15:0] attempts_o
);

	gt_pkg::gt_status_t status_m;
	gt_pkg::gt_status_t status_s;
	gt_pkg::fsm_state_t state_q;
	gt_pkg::fsm_state_t state_d;
	logic [31:0] cnt;
	logic tmo;
	logic tmo_l;
	logic pll_ok;
	logic phase_ok;
	logic far_aligned;
	logic [15:0] attempt_cnt;
	logic [16:0] phase_x5;

	// two-flop synchronizer for the whole status word
	always_ff @(posedge CPLLLOCKDETCLK or posedge reset) begin
		if (reset) begin
			status_m <= '0;
			status_s <= '0;
		end else begin
			status_m <= status_i;
			status_s <= status_m;
		end
	end

	assign cdrlock_sync_o = status_s.rx_cdrlock;
	assign txph_sync_o = status_s.tx_phaligndone;
	assign rxph_sync_o = status_s.rx_phaligndone;

	assign tmo = cnt == tmo_short;
	assign tmo_l = cnt == tmo_long;
	assign pll_ok = status_s.cpll_lock & ~status_s.cpll_fbclk_lost & ~status_s.cpll_refclk_lost;

	// 14-bit phase times five, top five bits
	assign phase_x5 = {3'b000, txphase_i[13:0]} + {1'b0, txphase_i[13:0], 2'b00};
	assign phase_ok = bypass_txphcheck_i | (phase_x5[16:12] == txphtarget_i);

	always_ff @(posedge CPLLLOCKDETCLK or posedge reset) begin
		if (reset) begin
			state_q <= gt_pkg::IDLE;
			cnt <= '0;
		end else begin
			state_q <= state_d;
			cnt <= (state_d == state_q && state_q != gt_pkg::IDLE) ? cnt + 1'b1 : '0;
		end
	end

	always_comb begin
		case (state_q)
			gt_pkg::IDLE: state_d = gt_pkg::TX_WAIT;
			gt_pkg::TX_WAIT: state_d = tmo ? gt_pkg::TX_TMO :
				(cnt == `GT_WAIT_500NS) ? gt_pkg::CPLL_RESET : gt_pkg::TX_WAIT;
			gt_pkg::CPLL_RESET: state_d = tmo ? gt_pkg::TX_TMO :
				(cnt == `GT_CPLL_PULSE) ? gt_pkg::CPLL_WAIT : gt_pkg::CPLL_RESET;
			gt_pkg::CPLL_WAIT: state_d = tmo ? gt_pkg::TX_TMO :
				status_s.cpll_lock ? gt_pkg::MMCM_WAIT : gt_pkg::CPLL_WAIT;
			gt_pkg::MMCM_WAIT: state_d = tmo ? gt_pkg::TX_TMO :
				status_s.mmcm_lock ? gt_pkg::PMA_TX_RESET : gt_pkg::MMCM_WAIT;
			gt_pkg::PMA_TX_RESET: state_d = tmo ? gt_pkg::TX_TMO :
				(cnt == `GT_PMA_PULSE) ? gt_pkg::PMA_TX_WAIT : gt_pkg::PMA_TX_RESET;
			gt_pkg::PMA_TX_WAIT: state_d = tmo_l ? gt_pkg::TX_TMO :
				(status_s.tx_resetdone & pll_ok) ? gt_pkg::PMA_RX_RESET : gt_pkg::PMA_TX_WAIT;
			gt_pkg::PMA_RX_RESET: state_d = tmo ? gt_pkg::RX_TMO :
				(cnt == `GT_PMA_PULSE) ? gt_pkg::PMA_RX_WAIT : gt_pkg::PMA_RX_RESET;
			gt_pkg::PMA_RX_WAIT: state_d = tmo_l ? gt_pkg::RX_TMO :
				(status_s.tx_resetdone & status_s.rx_resetdone & pll_ok) ?
				gt_pkg::TXDLY_RESET : gt_pkg::PMA_RX_WAIT;
			gt_pkg::TXDLY_RESET: state_d = tmo ? gt_pkg::TX_TMO :
				(cnt == `GT_DLY_PULSE) ? gt_pkg::TXDLY_WAIT : gt_pkg::TXDLY_RESET;
			gt_pkg::TXDLY_WAIT: state_d = tmo ? gt_pkg::TX_TMO :
				tx_phdone_i ? gt_pkg::PH_STB1 : gt_pkg::TXDLY_WAIT;
			gt_pkg::PH_STB1: state_d = tmo ? gt_pkg::TX_TMO :
				stb_txphase_i ? gt_pkg::PH_STB2 : gt_pkg::PH_STB1;
			gt_pkg::PH_STB2: state_d = tmo ? gt_pkg::TX_TMO :
				stb_txphase_i ? gt_pkg::PH_CHECK : gt_pkg::PH_STB2;
			gt_pkg::PH_CHECK: state_d = phase_ok ? gt_pkg::RX_WAIT : gt_pkg::TX_WAIT; // retry
			gt_pkg::RX_WAIT: state_d = tmo ? gt_pkg::RX_TMO :
				(cnt == `GT_WAIT_500NS) ? gt_pkg::CDR_WAIT : gt_pkg::RX_WAIT;
			gt_pkg::CDR_WAIT: state_d = cdr_locked_i ? gt_pkg::CDR_STABLE : gt_pkg::CDR_WAIT;
			gt_pkg::CDR_STABLE: state_d = (cnt == cdr_stable) ? gt_pkg::RXDLY_RESET :
				cdr_locked_i ? gt_pkg::CDR_STABLE : gt_pkg::CDR_WAIT;
			gt_pkg::RXDLY_RESET: state_d = tmo ? gt_pkg::RX_TMO :
				(cnt == `GT_DLY_PULSE) ? gt_pkg::RXDLY_WAIT : gt_pkg::RXDLY_RESET;
			gt_pkg::RXDLY_WAIT: state_d = tmo ? gt_pkg::RX_TMO :
				rx_phdone_i ? gt_pkg::ALIGN1 : gt_pkg::RXDLY_WAIT;
			gt_pkg::ALIGN1: state_d = tmo ? gt_pkg::RX_TMO :
				!cdr_locked_i ? gt_pkg::RX_WAIT :
				status_s.rx_byteisaligned ? gt_pkg::ALIGN2 : gt_pkg::ALIGN1;
			gt_pkg::ALIGN2: state_d = tmo ? gt_pkg::RX_TMO :
				!cdr_locked_i ? gt_pkg::RX_WAIT :
				!status_s.rx_byteisaligned ? gt_pkg::ALIGN1 :
				(cnt == `GT_ALIGN_HOLD) ? gt_pkg::ALIGN2_CHK : gt_pkg::ALIGN2;
			gt_pkg::ALIGN2_CHK: state_d = tmo ? gt_pkg::RX_TMO :
				!cdr_locked_i ? gt_pkg::RX_WAIT :
				!status_s.rx_byteisaligned ? gt_pkg::ALIGN1 :
				far_aligned ? gt_pkg::ALIGN3 : gt_pkg::ALIGN2;
			gt_pkg::ALIGN3: state_d = tmo ? gt_pkg::RX_TMO :
				!cdr_locked_i ? gt_pkg::RX_WAIT :
				!status_s.rx_byteisaligned ? gt_pkg::ALIGN1 :
				(cnt == `GT_ALIGN_HOLD) ? gt_pkg::DATA : gt_pkg::ALIGN3;
			// far end restarting its handshake pulls us back in step
			gt_pkg::DATA: state_d = !(pll_ok & status_s.mmcm_lock) ? gt_pkg::TX_WAIT :
				!cdr_locked_i ? gt_pkg::RX_WAIT :
				rx_err_i ? gt_pkg::RX_ERR :
				!status_s.rx_byteisaligned ? gt_pkg::ALIGN1 :
				align1_seen_i ? gt_pkg::ALIGN2 :
				align2_seen_i ? gt_pkg::ALIGN3 : gt_pkg::DATA;
			gt_pkg::RX_ERR: state_d = gt_pkg::ALIGN1;
			gt_pkg::TX_TMO: state_d = gt_pkg::TX_WAIT;
			gt_pkg::RX_TMO: state_d = gt_pkg::TX_WAIT;
			default: state_d = gt_pkg::IDLE;
		endcase
	end

	// outputs follow the state being entered
	always_ff @(posedge CPLLLOCKDETCLK or posedge reset) begin
		if (reset) begin
			ctrl_o <= '0;
			req_o <= '{req: gt_pkg::REQ_COMMA, seldata: 1'b0};
			done_o <= 1'b0;
			far_aligned <= 1'b0;
			attempt_cnt <= '0;
			attempts_o <= '0;
		end else begin
			case (state_d)
				gt_pkg::TX_WAIT: begin
					ctrl_o <= '{cpll_reset: 1'b1, mmcm_reset: 1'b1, gttx_reset: 1'b1,
						gtrx_reset: 1'b1, default: 1'b0};
					req_o <= '{req: gt_pkg::REQ_COMMA, seldata: 1'b0};
					done_o <= 1'b0;
				end
				gt_pkg::CPLL_RESET: begin
					ctrl_o.cpll_reset <= 1'b1;
					done_o <= 1'b0;
					if (state_q != gt_pkg::CPLL_RESET) begin
						attempt_cnt <= attempt_cnt + 1'b1;
					end
				end
				gt_pkg::CPLL_WAIT: ctrl_o.cpll_reset <= 1'b0;
				gt_pkg::MMCM_WAIT: begin
					ctrl_o.mmcm_reset <= 1'b0;
					ctrl_o.gttx_reset <= 1'b0;
					ctrl_o.gtrx_reset <= 1'b0;
				end
				gt_pkg::PMA_TX_RESET: begin
					ctrl_o.gttx_reset <= 1'b1;
					ctrl_o.gtrx_reset <= 1'b1;
				end
				gt_pkg::PMA_TX_WAIT: begin
					ctrl_o.gttx_reset <= 1'b0;
					ctrl_o.gtrx_reset <= 1'b0;
				end
				gt_pkg::PMA_RX_RESET: ctrl_o.gtrx_reset <= 1'b1;
				gt_pkg::PMA_RX_WAIT: ctrl_o.gtrx_reset <= 1'b0;
				gt_pkg::TXDLY_RESET: begin
					ctrl_o.txdly_sreset <= 1'b1;
					far_aligned <= 1'b0;
				end
				gt_pkg::TXDLY_WAIT: ctrl_o.txdly_sreset <= 1'b0;
				gt_pkg::PH_STB1: done_o <= 1'b1; // tx side is up
				gt_pkg::RX_WAIT: req_o <= '{req: gt_pkg::REQ_ALIGN1, seldata: 1'b0};
				gt_pkg::RXDLY_RESET: ctrl_o.rxdly_sreset <= 1'b1;
				gt_pkg::RXDLY_WAIT: ctrl_o.rxdly_sreset <= 1'b0;
				gt_pkg::ALIGN1: begin
					req_o <= '{req: gt_pkg::REQ_ALIGN1, seldata: 1'b0};
					if (align2_seen_i) far_aligned <= 1'b1;
				end
				gt_pkg::ALIGN2, gt_pkg::ALIGN2_CHK: begin
					req_o <= '{req: gt_pkg::REQ_ALIGN2, seldata: 1'b0};
					if (align2_seen_i) far_aligned <= 1'b1;
				end
				gt_pkg::ALIGN3: req_o <= '{req: gt_pkg::REQ_ALIGN3, seldata: 1'b0};
				gt_pkg::DATA: begin
					req_o <= '{req: gt_pkg::REQ_COMMA, seldata: 1'b1};
					done_o <= 1'b1;
					far_aligned <= 1'b0;
					// a realign without a new pll reset keeps the last count
					if (state_q != gt_pkg::DATA && attempt_cnt != '0) begin
						attempts_o <= attempt_cnt;
						attempt_cnt <= '0;
					end
				end
				gt_pkg::RX_ERR: done_o <= 1'b0;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/link_word_codec.sv
`timescale 1ns/100ps
`default_nettype none

`include "gt_consts.svh"

module link_word_codec (
	input wire logic CPLLLOCKDETCLK,
	input wire logic reset,
	input wire gt_pkg::link_req_t req_i,
	input wire gt_pkg::link_word_t tx_user_word_i,
	input wire gt_pkg::link_word_t rx_word_i,
	input wire logic [`GT_DBYTE-1:0] rx_err_i,
	output gt_pkg::link_word_t tx_word_o,
	output logic align1_seen_o,
	output logic align2_seen_o,
	output logic rx_err_o
);

	// K28.5 in the low byte, sequence number above it
	function automatic gt_pkg::link_word_t make_marker(input logic [7:0] seq);
		gt_pkg::link_word_t w;
		w.marker.seq = seq;
		w.marker.k28 = `GT_COMMA_K;
		w.marker.k = 2'b01;
		return w;
	endfunction

	logic rx_is_marker;

	// only the low byte may be a control character
	assign rx_is_marker = (rx_word_i.raw.k == 2'b01) && (rx_word_i.marker.k28 == `GT_COMMA_K);

	always_ff @(posedge CPLLLOCKDETCLK or posedge reset) begin
		if (reset) begin
			tx_word_o <= make_marker(8'h00);
		end else if (req_i.seldata) begin
			tx_word_o.raw <= tx_user_word_i.raw;
		end else begin
			case (req_i.req)
				gt_pkg::REQ_ALIGN1: tx_word_o <= make_marker(`GT_SEQ_ALIGN1);
				gt_pkg::REQ_ALIGN2: tx_word_o <= make_marker(`GT_SEQ_ALIGN2);
				gt_pkg::REQ_ALIGN3: tx_word_o <= make_marker(`GT_SEQ_ALIGN3);
				default: tx_word_o <= make_marker(8'h00); // idle comma
			endcase
		end
	end

	always_ff @(posedge CPLLLOCKDETCLK or posedge reset) begin
		if (reset) begin
			align1_seen_o <= 1'b0;
			align2_seen_o <= 1'b0;
			rx_err_o <= 1'b0;
		end else begin
			align1_seen_o <= rx_is_marker && rx_word_i.marker.seq == `GT_SEQ_ALIGN1;
			align2_seen_o <= rx_is_marker && rx_word_i.marker.seq == `GT_SEQ_ALIGN2;
			rx_err_o <= |rx_err_i; // disparity or not-in-table on any byte
		end
	end

endmodule

`default_nettype wire

//--- rtl/phalign_done_qual.sv
`timescale 1ns/100ps
`default_nettype none

module phalign_done_qual (
	input wire logic CPLLLOCKDETCLK,
	input wire logic reset,
	input wire logic dly_sreset_i,
	input wire logic phaligndone_i,
	output logic qualified_o
);

	logic done_d;
	logic first_edge; // armed by the aligner reset
	logic done_rise;

	assign done_rise = phaligndone_i & ~done_d;

	always_ff @(posedge CPLLLOCKDETCLK or posedge reset) begin
		if (reset) begin
			done_d <= 1'b0;
			first_edge <= 1'b0;
			qualified_o <= 1'b0;
		end else begin
			done_d <= phaligndone_i;
			if (dly_sreset_i) begin
				first_edge <= 1'b1;
				qualified_o <= 1'b0;
			end else if (done_rise) begin
				// first edge is the aligner's initial pass, not the real lock
				first_edge <= 1'b0;
				if (!first_edge) begin
					qualified_o <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- tb/gt_bringup_asserts.sv
`timescale 1ns/100ps
`default_nettype none

`include "gt_consts.svh"

module gt_bringup_asserts (
	input wire logic CPLLLOCKDETCLK,
	input wire logic reset,
	input wire gt_pkg::gt_ctrl_t ctrl_o,
	input wire gt_pkg::link_word_t tx_word_o,
	input wire logic done_o
);

	int fail_cnt = 0;

	// done only once the pll and pma resets are all released
	done_vs_reset: assert property (@(posedge CPLLLOCKDETCLK) disable iff (reset)
		!(done_o && (ctrl_o.cpll_reset | ctrl_o.mmcm_reset | ctrl_o.gttx_reset |
		ctrl_o.gtrx_reset | ctrl_o.txdly_sreset)))
		else begin
			$error("done_o high while a transceiver reset is active");
			fail_cnt++;
		end

	cpll_pulse_len: assert property (@(posedge CPLLLOCKDETCLK) disable iff (reset)
		$rose(ctrl_o.cpll_reset) |-> ctrl_o.cpll_reset [*`GT_CPLL_PULSE])
		else begin
			$error("cpll_reset pulse shorter than its minimum length");
			fail_cnt++;
		end

	// only the low byte ever carries a K character
	tx_k_flags: assert property (@(posedge CPLLLOCKDETCLK) disable iff (reset)
		tx_word_o.raw.k[1] == 1'b0)
		else begin
			$error("tx_word_o has the high K flag set");
			fail_cnt++;
		end

endmodule

bind gt_bringup_top gt_bringup_asserts u_asserts (
	.CPLLLOCKDETCLK(CPLLLOCKDETCLK),
	.reset(reset),
	.ctrl_o(ctrl_o),
	.tx_word_o(tx_word_o),
	.done_o(done_o)
);

`default_nettype wire

//--- tb/gt_bringup_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "gt_consts.svh"

module gt_bringup_checker (
	input wire logic CPLLLOCKDETCLK,
	input wire logic reset,
	input wire gt_pkg::gt_ctrl_t ctrl_i,
	input wire gt_pkg::link_word_t tx_word_i,
	input wire logic done_i,
	input wire logic [15:0] attempts_i,
	input wire gt_pkg::link_word_t tx_user_word_i,
	input wire logic mark_i, // fault point of the row
	input wire logic check_i,
	input wire logic [7:0] row_i,
	input wire logic [15:0] exp_attempts_i,
	input wire logic exp_done_i,
	input wire logic exp_realign_i,
	input wire logic timed_out_i,
	output int tests_o,
	output int fails_o
);

	gt_pkg::link_word_t user_q;
	logic rst_seen;
	logic after_rst;
	logic prev_data;
	logic marked;
	logic [7:0] last_seq;
	int realigns;
	int errs;

	initial begin
		tests_o = 0;
		fails_o = 0;
		errs = 0;
		rst_seen = 1'b0;
		after_rst = 1'b0;
	end

	always @(posedge CPLLLOCKDETCLK) begin
		if (reset) begin
			rst_seen = 1'b1;
			after_rst = 1'b0;
			prev_data = 1'b0;
			marked = 1'b0;
			last_seq = 8'h00;
			realigns = 0;
		end else begin
			if (rst_seen) begin // first cycle out of reset
				if (ctrl_i != 6'b000000 || done_i) begin
					$display("FAIL ctrl_o/done_o expected 00/0 got %h/%h", ctrl_i, done_i);
					errs++;
				end
				if (!(tx_word_i.raw.k == 2'b01 && tx_word_i.marker.k28 == `GT_COMMA_K &&
					tx_word_i.marker.seq == 8'h00)) begin
					$display("FAIL tx_word_o expected %h got %h", 18'h002f1, tx_word_i);
					errs++;
				end
				rst_seen = 1'b0;
				after_rst = 1'b1;
			end else if (after_rst) begin
				if (ctrl_i != 6'b111100) begin
					$display("FAIL ctrl_o expected %h got %h", 6'b111100, ctrl_i);
					errs++;
				end
				after_rst = 1'b0;
			end
			if (tx_word_i.raw.k == 2'b00) begin
				// user data, one cycle behind the input
				if (tx_word_i != user_q) begin
					$display("FAIL tx_word_o expected %h got %h", user_q, tx_word_i);
					errs++;
				end
				if (!prev_data && last_seq != `GT_SEQ_ALIGN3) begin
					$display("user data started without markers 1, 2 and 3 before it");
					errs++;
				end
				prev_data = 1'b1;
			end else if (tx_word_i.raw.k == 2'b01 && tx_word_i.marker.k28 == `GT_COMMA_K) begin
				prev_data = 1'b0;
				if (tx_word_i.marker.seq == 8'h00) begin
					last_seq = 8'h00;
				end else if (tx_word_i.marker.seq != last_seq) begin
					if (tx_word_i.marker.seq != `GT_SEQ_ALIGN1 &&
						tx_word_i.marker.seq != last_seq + 8'h01) begin
						$display("marker %0d sent after marker %0d, out of order",
							tx_word_i.marker.seq, last_seq);
						errs++;
					end
					if (tx_word_i.marker.seq == `GT_SEQ_ALIGN1 && marked) realigns++;
					last_seq = tx_word_i.marker.seq;
				end
			end else begin
				$display("FAIL tx_word_o unexpected word %h", tx_word_i);
				errs++;
			end
			if (mark_i) begin
				marked = 1'b1;
				realigns = 0;
			end
		end
		if (check_i) begin
			if (timed_out_i) begin
				$display("link did not come up in time");
				errs++;
			end
			if (attempts_i != exp_attempts_i) begin
				$display("FAIL attempts_o expected %h got %h", exp_attempts_i, attempts_i);
				errs++;
			end
			if (done_i != exp_done_i) begin
				$display("FAIL done_o expected %h got %h", exp_done_i, done_i);
				errs++;
			end
			if ((realigns != 0) != exp_realign_i) begin
				$display("realign after the fault was %0s but %0s was expected",
					realigns != 0 ? "seen" : "absent", exp_realign_i ? "one" : "none");
				errs++;
			end
			tests_o++;
			if (errs != 0) fails_o++;
			$display("row %0d: %0s (%0d errors)", row_i, errs == 0 ? "ok" : "FAILED", errs);
			errs = 0;
		end
		user_q = tx_user_word_i;
	end

endmodule

`default_nettype wire

//--- tb/gt_bringup_tb.sv
`timescale 1ns/100ps
`default_nettype none

module gt_bringup_tb;

	localparam int CLK_PERIOD = 4;
	localparam int TMO_SHORT = 3000;
	localparam int TMO_LONG = 6000;
	localparam int ROWS = 7;
	localparam int LINK_TMO = TMO_LONG + 2000;
	localparam int WATCHDOG_CYCLES = ROWS * (TMO_LONG + 2000);

	localparam logic [2:0] F_NONE = 3'd0;
	localparam logic [2:0] F_PH_ONCE = 3'd1; // first phase check misses
	localparam logic [2:0] F_PLL_HOLD = 3'd2; // first pll lock withheld
	localparam logic [2:0] F_RX_ERR = 3'd3;
	localparam logic [2:0] F_CDR_SHORT = 3'd4;
	localparam logic [2:0] F_CDR_LONG = 3'd5;

	typedef struct packed {
		logic [15:0] txphase;
		logic [4:0] target;
		logic bypass;
		logic [2:0] fault;
		logic [15:0] exp_attempts;
		logic exp_done;
		logic exp_realign;
	} row_t;

	row_t rows [ROWS];

	logic CPLLLOCKDETCLK = 1'b0;
	logic reset;
	gt_pkg::gt_status_t status;
	gt_pkg::link_word_t rx_word;
	logic [1:0] rx_err;
	gt_pkg::link_word_t tx_user_word;
	logic stb_txphase;
	logic bypass;
	logic [15:0] txphase;
	logic [4:0] txphtarget;
	gt_pkg::gt_ctrl_t ctrl;
	gt_pkg::link_word_t tx_word;
	logic done;
	logic [15:0] attempts;

	// requests from the scenario loop to the transceiver model
	logic clear_req;
	logic err_req;
	int drop_req;
	row_t cfg;
	logic [15:0] cfg_good;

	logic mark;
	logic check;
	logic [7:0] row_idx;
	logic row_tmo;
	int tests;
	int fails;

	// transceiver model state
	integer seed = 32'he714;
	gt_pkg::gt_ctrl_t pc;
	logic rd_prev;
	logic cdr_raw;
	logic hold_pll;
	logic ph_used;
	logic done_q;
	int cpll_t, mmcm_t, txrd_t, rxrd_t, cdr_t;
	int txph_t, rxph_t, txph_d, rxph_d;
	int stb_t;
	int drop_cnt;

	gt_bringup_top #(
		.tmo_short(TMO_SHORT),
		.tmo_long(TMO_LONG),
		.cdr_stable(50)
	) UUT (
		.CPLLLOCKDETCLK(CPLLLOCKDETCLK),
		.reset(reset),
		.status_i(status),
		.rx_word_i(rx_word),
		.rx_err_i(rx_err),
		.tx_user_word_i(tx_user_word),
		.stb_txphase_i(stb_txphase),
		.bypass_txphcheck_i(bypass),
		.txphase_i(txphase),
		.txphtarget_i(txphtarget),
		.ctrl_o(ctrl),
		.tx_word_o(tx_word),
		.done_o(done),
		.attempts_o(attempts)
	);

	gt_bringup_checker u_checker (
		.CPLLLOCKDETCLK(CPLLLOCKDETCLK),
		.reset(reset),
		.ctrl_i(ctrl),
		.tx_word_i(tx_word),
		.done_i(done),
		.attempts_i(attempts),
		.tx_user_word_i(tx_user_word),
		.mark_i(mark),
		.check_i(check),
		.row_i(row_idx),
		.exp_attempts_i(cfg.exp_attempts),
		.exp_done_i(cfg.exp_done),
		.exp_realign_i(cfg.exp_realign),
		.timed_out_i(row_tmo),
		.tests_o(tests),
		.fails_o(fails)
	);

	always #(CLK_PERIOD / 2) CPLLLOCKDETCLK = ~CPLLLOCKDETCLK;

	// 5-bit phase from the 14-bit measurement, times five over 4096
	function automatic logic [4:0] phase_of(input logic [15:0] ph);
		logic [16:0] prod;
		prod = 17'(ph[13:0]) * 17'd5;
		return prod[16:12];
	endfunction

	function automatic logic [15:0] phase_for(input logic [4:0] target);
		logic [15:0] found;
		found = 16'h0000;
		for (int v = 16383; v >= 0; v--) begin
			if (phase_of(16'(v)) == target) found = 16'(v);
		end
		return found;
	endfunction

	function int rnd_delay();
		rnd_delay = 4 + ($unsigned($random(seed)) % 28);
	endfunction

	// lock or done flag that follows the release of a reset
	task automatic step_lock(input logic rst_now, input logic rst_was, input logic allow,
		inout int t, inout logic flag);
		if (rst_now) begin
			flag = 1'b0;
			t = -1;
		end else if (rst_was && allow) begin
			t = rnd_delay();
		end else if (t == 0) begin
			flag = 1'b1;
			t = -1;
		end else if (t > 0) begin
			t = t - 1;
		end
	endtask

	// two phase-align-done pulses, the second one stays high
	task automatic step_phalign(input logic rst_now, input logic rst_was,
		inout int t, inout int d, inout logic flag);
		if (rst_now) begin
			t = -1;
		end else if (rst_was) begin
			d = rnd_delay();
			t = 0;
		end else if (t >= 0 && t < d + 8) begin
			t = t + 1;
		end
		flag = (t >= d && t < d + 4) || (t >= d + 8);
	endtask

	always @(posedge CPLLLOCKDETCLK) begin
		#1;
		tx_user_word.raw.data = 16'($random(seed));
		tx_user_word.raw.k = 2'b00;
		rx_word = tx_word; // far end echoes what we send
		rx_err = err_req ? 2'b10 : 2'b00;
		txphtarget = cfg.target;
		bypass = cfg.bypass;
		if (clear_req) begin
			status = '0;
			pc = '0;
			rd_prev = 1'b0;
			cdr_raw = 1'b0;
			hold_pll = (cfg.fault == F_PLL_HOLD);
			ph_used = 1'b0;
			done_q = 1'b0;
			{cpll_t, mmcm_t, txrd_t, rxrd_t, cdr_t} = {5{-32'sd1}};
			{txph_t, rxph_t, stb_t} = {3{-32'sd1}};
			txph_d = 4;
			rxph_d = 4;
			drop_cnt = 0;
			stb_txphase = 1'b0;
		end else begin
			step_lock(ctrl.cpll_reset, pc.cpll_reset, !hold_pll, cpll_t, status.cpll_lock);
			if (pc.cpll_reset && !ctrl.cpll_reset) hold_pll = 1'b0;
			step_lock(ctrl.mmcm_reset, pc.mmcm_reset, 1'b1, mmcm_t, status.mmcm_lock);
			step_lock(ctrl.gttx_reset, pc.gttx_reset, 1'b1, txrd_t, status.tx_resetdone);
			step_lock(ctrl.gtrx_reset, pc.gtrx_reset, 1'b1, rxrd_t, status.rx_resetdone);
			step_lock(!status.rx_resetdone, !rd_prev, 1'b1, cdr_t, cdr_raw);
			rd_prev = status.rx_resetdone;
			step_phalign(ctrl.txdly_sreset, pc.txdly_sreset, txph_t, txph_d,
				status.tx_phaligndone);
			step_phalign(ctrl.rxdly_sreset, pc.rxdly_sreset, rxph_t, rxph_d,
				status.rx_phaligndone);
			if (drop_req != 0) drop_cnt = drop_req;
			else if (drop_cnt > 0) drop_cnt--;
			status.rx_cdrlock = cdr_raw && drop_cnt == 0;
			status.rx_byteisaligned = cdr_raw;
			// two phase strobes after the tx side reports done
			if (done && !done_q) begin
				stb_t = 0;
				if (cfg.fault == F_PH_ONCE && !ph_used) begin
					txphase = cfg.txphase;
					ph_used = 1'b1;
				end else begin
					txphase = (cfg.fault == F_PH_ONCE) ? cfg_good : cfg.txphase;
				end
			end else if (stb_t >= 0 && stb_t < 8) begin
				stb_t++;
			end
			stb_txphase = (stb_t == 3 || stb_t == 6);
			done_q = done;
			pc = ctrl;
		end
	end

	task wait_link(output logic timed_out);
		int n;
		n = 0;
		while (!(done && tx_word.raw.k == 2'b00) && n < LINK_TMO) begin
			@(negedge CPLLLOCKDETCLK);
			n++;
		end
		timed_out = (n >= LINK_TMO);
	endtask

	task run_row(input int r);
		logic to;
		@(negedge CPLLLOCKDETCLK);
		cfg = rows[r];
		cfg_good = phase_for(rows[r].target);
		row_idx = 8'(r);
		row_tmo = 1'b0;
		clear_req = 1'b1;
		@(posedge CPLLLOCKDETCLK);
		#1 reset = 1'b1;
		repeat (3) @(posedge CPLLLOCKDETCLK);
		#1 reset = 1'b0;
		@(negedge CPLLLOCKDETCLK);
		clear_req = 1'b0;
		wait_link(to);
		row_tmo = to;
		repeat (20) @(negedge CPLLLOCKDETCLK);
		mark = 1'b1;
		case (cfg.fault)
			F_RX_ERR: err_req = 1'b1;
			F_CDR_SHORT: drop_req = 2;
			F_CDR_LONG: drop_req = 10;
			default: ;
		endcase
		@(negedge CPLLLOCKDETCLK);
		mark = 1'b0;
		err_req = 1'b0;
		drop_req = 0;
		repeat (50) @(negedge CPLLLOCKDETCLK);
		wait_link(to);
		row_tmo = row_tmo | to;
		repeat (5) @(negedge CPLLLOCKDETCLK);
		check = 1'b1;
		@(negedge CPLLLOCKDETCLK);
		check = 1'b0;
	endtask

	initial begin
		reset = 1'b1;
		status = '0;
		rx_word = '0;
		rx_err = 2'b00;
		tx_user_word = '0;
		stb_txphase = 1'b0;
		bypass = 1'b0;
		txphase = 16'h0000;
		txphtarget = 5'd0;
		clear_req = 1'b1;
		err_req = 1'b0;
		drop_req = 0;
		mark = 1'b0;
		check = 1'b0;
		row_idx = 8'd0;
		row_tmo = 1'b0;
		cfg = '0;
		cfg_good = 16'h0000;
		// txphase, target, bypass, fault, attempts, done, realign
		rows[0] = '{16'h1000, 5'd5, 1'b0, F_NONE, 16'd1, 1'b1, 1'b0};
		rows[1] = '{16'h1000, 5'd7, 1'b0, F_PH_ONCE, 16'd2, 1'b1, 1'b0};
		rows[2] = '{16'h1000, 5'd7, 1'b1, F_NONE, 16'd1, 1'b1, 1'b0};
		rows[3] = '{16'h2000, 5'd10, 1'b0, F_PLL_HOLD, 16'd2, 1'b1, 1'b0};
		rows[4] = '{16'h1000, 5'd5, 1'b0, F_RX_ERR, 16'd1, 1'b1, 1'b1};
		rows[5] = '{16'h1000, 5'd5, 1'b0, F_CDR_SHORT, 16'd1, 1'b1, 1'b0};
		rows[6] = '{16'h1000, 5'd5, 1'b0, F_CDR_LONG, 16'd1, 1'b1, 1'b1};
		for (int r = 0; r < ROWS; r++) begin
			run_row(r);
		end
		repeat (2) @(negedge CPLLLOCKDETCLK);
		$display("tests run %0d, failing %0d, assertion failures %0d", tests, fails,
			UUT.u_asserts.fail_cnt);
		if (fails == 0 && tests == ROWS && UUT.u_asserts.fail_cnt == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired before all rows finished");
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire
